/* Makefile */
# Verilator flow for the software trace module

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_stm
	verilator --lint-only stm_pkg.sv stm_trace_if.sv stm_trace_collector.sv \
		stm_ringbuffer.sv stm_top.sv --top-module stm_top

# the log decides, a run that stops early has no pass line
sim:
	verilator --binary --assert -f flist.f --top-module tb_stm -o Vtb_stm
	./obj_dir/Vtb_stm > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
stm_pkg.sv
stm_trace_if.sv
stm_trace_collector.sv
stm_ringbuffer.sv
stm_top.sv
stm_assert.sv
tb_stm.sv

/* stm_assert.sv */
/*
 * ring buffer assertions
 * reset state, fill bound and a monotonic overflow count
 */

`timescale 1ns/100ps

module stm_assert #(
   parameter int depth = 8
   )
   (
   input logic                       clk_sample,
   input logic                       rst,
   input logic                       empty,
   input logic [$clog2(depth+1)-1:0] fill_count,
   input logic [15:0]                overflow_count
   );

   int fail_count;  // read by the testbench at the end
   initial fail_count = 0;

   // first edge out of reset sees an empty buffer
   empty_after_reset: assert property (@(posedge clk_sample) $fell(rst) |-> empty)
      else begin
         $error("buffer not empty after reset");
         fail_count++;
      end

   fill_bound: assert property (@(posedge clk_sample) disable iff (rst) fill_count <= depth)
      else begin
         $error("fill count above depth");
         fail_count++;
      end

   // saturates, never wraps back
   overflow_monotonic: assert property (@(posedge clk_sample) disable iff (rst)
      overflow_count >= $past(overflow_count))
      else begin
         $error("overflow count decreased");
         fail_count++;
      end

endmodule

bind stm_ringbuffer stm_assert #(.depth(depth)) rb_assert (
   .clk_sample     (clk_sample),
   .rst            (rst),
   .empty          (empty),
   .fill_count     (fill_count),
   .overflow_count (overflow_count)
);

/* stm_pkg.sv */
/*
 * software trace module, shared definitions
 * trace entry layout, field widths and the constants used to
 * spot debug l.nop instructions and r3 writes in writeback
 */

package stm_pkg;

   // field widths of one trace entry
   localparam int ts_width    = 32;  // timestamp
   localparam int value_width = 32;  // latched r3 contents
   localparam int id_width    = 16;  // low half of the l.nop

   // register file address of r3, the trace argument register
   localparam logic [4:0] r3_addr = 5'd3;

   // upper half of l.nop, the cpu ignores the low 16 bits
   // so software puts a trace id there, 0 means plain nop
   localparam logic [15:0] l_nop_msb = 16'h1500;

   // one captured trace, timestamp in the top bits
   typedef struct packed {
      logic [ts_width-1:0]    timestamp;  // sampled at the retire edge
      logic [value_width-1:0] value;      // r3 before the l.nop
      logic [id_width-1:0]    id;         // l.nop immediate
   } stm_trace_t;

   // flat width for the host side ports
   localparam int trace_width = $bits(stm_trace_t);

endpackage

/* stm_ringbuffer.sv */
/*
 * trace ring buffer
 * stores depth entries, a push into a full buffer drops the
 * oldest one and bumps a saturating overflow counter, the host
 * reads the oldest entry and removes it with a pop strobe
 */

`timescale 1ns/100ps

module stm_ringbuffer
   import stm_pkg::*;
   #(
   parameter int depth = 8  // power of two, 2 or more
   )
   (
   input  logic        clk_sample,
   input  logic        rst,

   // from the collector
   stm_trace_if.sink   trace,

   // host side
   input  logic        rd_en,           // pop strobe
   output stm_trace_t  rd_data,         // oldest entry
   output logic        empty,
   output logic [15:0] overflow_count   // entries lost to overwrite
   );

   localparam int aw = $clog2(depth);      // pointer bits
   localparam int cw = $clog2(depth + 1);  // fill count bits, holds depth
   localparam logic [cw-1:0] full_level = cw'(depth);

   stm_trace_t    mem [depth];  // entry storage
   logic [aw-1:0] wr_ptr;       // next slot to write
   logic [aw-1:0] rd_ptr;       // oldest entry
   logic [cw-1:0] fill_count;   // entries held
   logic          push;
   logic          pop;
   logic          full;
   logic          drop;         // oldest entry overwritten this cycle

   assign push  = trace.trace_enable;
   assign pop   = rd_en && !empty;  // strobe on empty is ignored
   assign full  = (fill_count == full_level);
   assign empty = (fill_count == '0);

   // full and no pop, the write lands on the oldest slot
   // full with a pop consumes that slot first, nothing lost
   assign drop  = push && full && !pop;

   // head of the queue straight from storage
   assign rd_data = mem[rd_ptr];

   // storage write, wr_ptr equals rd_ptr when full
   always_ff @(posedge clk_sample) begin
      if (push) begin
         mem[wr_ptr] <= trace.entry;
      end
   end

   // write pointer
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (push) begin
         wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
   end

   // read pointer, also moves when the oldest entry is dropped
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (pop || drop) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // fill level
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         fill_count <= '0;
      end else begin
         case ({push, pop})
            2'b10: begin
               if (!full) begin
                  fill_count <= fill_count + 1'b1;
               end
               // full: one in, one dropped
            end
            2'b01: fill_count <= fill_count - 1'b1;
            default: ;  // idle, or push and pop together
         endcase
      end
   end

   // lost entries, sticks at all ones
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         overflow_count <= '0;
      end else if (drop && (overflow_count != 16'hffff)) begin
         overflow_count <= overflow_count + 1'b1;
      end
   end

endmodule

/* stm_top.sv */
/*
 * software trace module top
 * trace collector feeding a ring buffer, host drains it with a
 * pop strobe and reads the overflow count
 */

`timescale 1ns/100ps

module stm_top
   import stm_pkg::*;
   #(
   parameter int depth = 8  // ring buffer entries, power of two
   )
   (
   input  logic                   clk_sample,
   input  logic                   rst,

   // cpu writeback stage
   input  logic [4:0]             rf_addrw,
   input  logic [31:0]            rf_dataw,
   input  logic                   rf_we,
   input  logic [31:0]            cpu_wb_insn,
   input  logic                   cpu_wb_freeze,

   // host side
   input  logic                   rd_en,          // pop strobe
   output logic [trace_width-1:0] rd_data,        // oldest entry, flat
   output logic                   empty,
   output logic [15:0]            overflow_count
   );

   stm_trace_t rb_rd_data;  // struct view of the head entry

   // collector to ring buffer
   stm_trace_if trace_bus ();

   stm_trace_collector u_collector (
      .clk_sample    (clk_sample),
      .rst           (rst),
      .rf_addrw      (rf_addrw),
      .rf_dataw      (rf_dataw),
      .rf_we         (rf_we),
      .cpu_wb_insn   (cpu_wb_insn),
      .cpu_wb_freeze (cpu_wb_freeze),
      .trace         (trace_bus.source)
   );

   stm_ringbuffer #(
      .depth (depth)
   ) u_ringbuffer (
      .clk_sample     (clk_sample),
      .rst            (rst),
      .trace          (trace_bus.sink),
      .rd_en          (rd_en),
      .rd_data        (rb_rd_data),
      .empty          (empty),
      .overflow_count (overflow_count)
   );

   // flatten for the host port, timestamp in the top bits
   assign rd_data = rb_rd_data;

endmodule

/* stm_trace_collector.sv */
/*
 * software trace collector
 * watches cpu writeback, keeps a copy of r3 and a free running
 * timestamp, and emits one trace entry per debug l.nop that
 * retires while the core is not frozen
 */

`timescale 1ns/100ps

module stm_trace_collector
   import stm_pkg::*;
   (
   input  logic        clk_sample,
   input  logic        rst,

   // writeback stage of the traced core
   input  logic [4:0]  rf_addrw,       // register file write address
   input  logic [31:0] rf_dataw,       // register file write data
   input  logic        rf_we,
   input  logic [31:0] cpu_wb_insn,    // instruction in writeback
   input  logic        cpu_wb_freeze,  // stage stalled

   // to the ring buffer
   stm_trace_if.source trace
   );

   logic [value_width-1:0] r3_data;    // last value written to r3
   logic [ts_width-1:0]    timestamp;  // cycles since reset release
   logic                   r3_write;
   logic                   debug_nop;

   // r3 write seen in writeback
   assign r3_write = rf_we && (rf_addrw == r3_addr);

   // l.nop with non zero immediate, only counts when the stage moves
   assign debug_nop = (cpu_wb_insn[31:16] == l_nop_msb) &&
                      (cpu_wb_insn[15:0] != '0) &&
                      !cpu_wb_freeze;

   // shadow copy of r3
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         r3_data <= '0;
      end else if (r3_write) begin
         r3_data <= rf_dataw;  // visible from the next cycle on
      end
   end

   // free running timestamp, 0 in the first cycle out of reset
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         timestamp <= '0;
      end else begin
         timestamp <= timestamp + 1'b1;  // wraps silently
      end
   end

   // enable pulse, one cycle after the l.nop edge
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         trace.trace_enable <= 1'b0;
      end else begin
         trace.trace_enable <= debug_nop;
      end
   end

   // entry payload, only loaded on a hit
   // r3 written in the same cycle is not included yet
   always_ff @(posedge clk_sample) begin
      if (debug_nop) begin
         trace.entry.timestamp <= timestamp;
         trace.entry.value     <= r3_data;
         trace.entry.id        <= cpu_wb_insn[id_width-1:0];
      end
   end

endmodule

/* stm_trace_if.sv */
/*
 * trace entry link, collector to ring buffer
 * one entry plus a single cycle enable, no back-pressure
 */

`timescale 1ns/100ps

interface stm_trace_if
   import stm_pkg::*;
   ();

   logic       trace_enable;  // one cycle per captured trace
   stm_trace_t entry;         // valid while trace_enable high

   // collector drives
   modport source (
      output trace_enable,
      output entry
   );

   // ring buffer takes every enabled cycle
   modport sink (
      input trace_enable,
      input entry
   );

endinterface

/* tb_stm.sv */
/*
 * testbench for the software trace module
 * drives writeback traffic and host pops from an LCG and checks
 * every cycle against a cycle based model of collector and buffer
 */

`timescale 1ns/100ps

module tb_stm
   import stm_pkg::*;
   ();

   localparam int depth = 8;
   localparam int wait_limit = 200;            // cycles per wait loop
   localparam logic [31:0] idle_insn = 32'h1500_0000;  // l.nop 0

   logic                   clk_sample;
   logic                   rst;
   logic [4:0]             rf_addrw;
   logic [31:0]            rf_dataw;
   logic                   rf_we;
   logic [31:0]            cpu_wb_insn;
   logic                   cpu_wb_freeze;
   logic                   rd_en;
   logic [trace_width-1:0] rd_data;
   logic                   empty;
   logic [15:0]            overflow_count;

   // model state
   stm_trace_t          model_q [$];  // buffer contents with the oldest first
   stm_trace_t          pend_entry;   // formed at the last edge
   logic                pend_valid;
   logic [31:0]         shadow_r3;
   logic [ts_width-1:0] model_ts;
   logic [15:0]         model_ovf;
   logic [31:0]         lcg_state;
   string               test_name;

   stm_top #(
      .depth (depth)
   ) uut (
      .clk_sample     (clk_sample),
      .rst            (rst),
      .rf_addrw       (rf_addrw),
      .rf_dataw       (rf_dataw),
      .rf_we          (rf_we),
      .cpu_wb_insn    (cpu_wb_insn),
      .cpu_wb_freeze  (cpu_wb_freeze),
      .rd_en          (rd_en),
      .rd_data        (rd_data),
      .empty          (empty),
      .overflow_count (overflow_count)
   );

   always #50 clk_sample = ~clk_sample;  // 100 ns period

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // l.nop with non zero immediate on a moving stage
   function automatic logic is_debug_nop(input logic [31:0] insn, input logic freeze);
      return (insn[31:16] == 16'h1500) && (insn[15:0] != 16'h0000) && !freeze;
   endfunction

   task automatic halt_failed();
      $display("TEST FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [trace_width-1:0] expected,
                              input logic [trace_width-1:0] actual);
      if (expected !== actual) begin
         $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
         halt_failed();
      end
   endtask

   task automatic check_outputs();
      check_value("empty", trace_width'(model_q.size() == 0), trace_width'(empty));
      check_value("overflow_count", trace_width'(model_ovf), trace_width'(overflow_count));
      if (model_q.size() != 0) begin
         check_value("rd_data", model_q[0], rd_data);  // head entry
      end
   endtask

   // one clock with the inputs already applied
   task automatic step();
      stm_trace_t new_entry;
      logic       new_valid;
      logic       do_pop;
      do_pop    = rd_en && (model_q.size() != 0);  // pop on empty ignored
      new_valid = is_debug_nop(cpu_wb_insn, cpu_wb_freeze);
      new_entry.timestamp = model_ts;
      new_entry.value     = shadow_r3;              // r3 before this edge
      new_entry.id        = cpu_wb_insn[15:0];
      @(posedge clk_sample);
      if (do_pop) begin
         void'(model_q.pop_front());
      end
      if (pend_valid) begin
         if (model_q.size() == depth) begin        // oldest lost when full
            void'(model_q.pop_front());
            if (model_ovf != 16'hffff) begin
               model_ovf = model_ovf + 16'd1;
            end
         end
         model_q.push_back(pend_entry);
      end
      pend_valid = new_valid;
      pend_entry = new_entry;
      if (rf_we && (rf_addrw == 5'd3)) begin
         shadow_r3 = rf_dataw;                      // after the entry is formed
      end
      model_ts = model_ts + 1;
      #10;                                         // drive and sample point
      check_outputs();
   endtask

   task automatic run_cycle(input logic we, input logic [4:0] addr, input logic [31:0] data,
                            input logic [31:0] insn, input logic freeze, input logic pop);
      rf_we         = we;
      rf_addrw      = addr;
      rf_dataw      = data;
      cpu_wb_insn   = insn;
      cpu_wb_freeze = freeze;
      rd_en         = pop;
      step();
   endtask

   task automatic idle_cycle(input logic pop);
      run_cycle(1'b0, 5'd0, 32'd0, idle_insn, 1'b0, pop);
   endtask

   // bounded pop until empty
   task automatic drain_all();
      int n;
      n = 0;
      while (empty !== 1'b1) begin
         if (n == wait_limit) begin
            $display("timeout, the buffer did not run empty while draining");
            halt_failed();
         end
         idle_cycle(1'b1);
         n++;
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] data;
      logic [31:0] insn;
      logic [31:0] last_r3;
      logic [15:0] id;
      logic [15:0] ovf_before;
      logic [4:0]  addr;
      logic        freeze;
      logic        pop_req;
      stm_trace_t  expected;
      int          i;
      int          k;
      int          n_writes;
      clk_sample    = 1'b0;
      rst           = 1'b1;
      rf_addrw      = 5'd0;
      rf_dataw      = 32'd0;
      rf_we         = 1'b0;
      cpu_wb_insn   = idle_insn;
      cpu_wb_freeze = 1'b0;
      rd_en         = 1'b0;
      lcg_state     = 32'd24075;  // fixed seed
      test_name     = "reset";
      repeat (16) @(posedge clk_sample);
      #10;
      rst        = 1'b0;
      model_q.delete();
      pend_valid = 1'b0;
      shadow_r3  = 32'd0;
      model_ts   = '0;  // timestamp reads 0 right after release
      model_ovf  = 16'd0;
      last_r3    = 32'd0;
      check_outputs();

      // r3 latch and entry content with two cycle latency
      test_name = "r3_latch";
      for (i = 0; i < 6; i++) begin
         r = lcg_next();
         n_writes = int'(r[17:16]) + 1;
         for (k = 0; k < n_writes; k++) begin
            r    = lcg_next();
            data = lcg_next();
            addr = r[20] ? 5'd3 : r[25:21];  // mostly r3 and some others
            if (addr == 5'd3) begin
               last_r3 = data;
            end
            run_cycle(1'b1, addr, data, idle_insn, 1'b0, 1'b0);
         end
         r  = lcg_next();
         id = (r[31:16] == 16'h0000) ? 16'h0001 : r[31:16];
         expected.timestamp = model_ts;
         expected.value     = last_r3;
         expected.id        = id;
         run_cycle(1'b0, 5'd0, 32'd0, {16'h1500, id}, 1'b0, 1'b0);
         idle_cycle(1'b0);
         check_value("entry", expected, rd_data);
         idle_cycle(1'b1);
         check_value("empty after pop", trace_width'(1'b1), trace_width'(empty));
      end

      // nothing qualifies here
      test_name = "filtering";
      for (i = 0; i < 40; i++) begin
         r    = lcg_next();
         data = lcg_next();
         insn = lcg_next();
         freeze = r[18];
         case (r[17:16])
            2'd0: insn = idle_insn;              // plain l.nop
            2'd1: insn[31:26] = 6'h27;           // l.addi
            default: begin
               insn   = {16'h1500, r[31:16] | 16'h0001};
               freeze = 1'b1;                    // debug nop while frozen
            end
         endcase
         run_cycle(r[19], r[24:20], data, insn, freeze, 1'b0);
      end
      idle_cycle(1'b0);
      idle_cycle(1'b0);
      check_value("empty", trace_width'(1'b1), trace_width'(empty));
      check_value("model queue size", '0, trace_width'(model_q.size()));

      // r3 write on the l.nop edge is not in the entry
      test_name = "same_cycle_r3";
      data = lcg_next();
      run_cycle(1'b1, 5'd3, data, idle_insn, 1'b0, 1'b0);
      expected.timestamp = model_ts;
      expected.value     = data;
      expected.id        = 16'h00a5;
      r = lcg_next();
      run_cycle(1'b1, 5'd3, r, {16'h1500, 16'h00a5}, 1'b0, 1'b0);
      idle_cycle(1'b0);
      check_value("old r3", expected, rd_data);
      expected.timestamp = model_ts;
      expected.value     = r;                     // now visible
      expected.id        = 16'h005a;
      run_cycle(1'b0, 5'd0, 32'd0, {16'h1500, 16'h005a}, 1'b0, 1'b1);
      idle_cycle(1'b0);
      check_value("new r3", expected, rd_data);
      drain_all();

      // depth + 5 pushes without pops
      test_name  = "overwrite";
      ovf_before = model_ovf;
      for (i = 0; i < depth + 5; i++) begin
         run_cycle(1'b0, 5'd0, 32'd0, {16'h1500, 16'(16'h0100 + i)}, 1'b0, 1'b0);
      end
      idle_cycle(1'b0);
      check_value("dropped count", trace_width'(ovf_before + 16'd5),
                  trace_width'(overflow_count));
      for (i = 0; i < depth; i++) begin
         check_value("drained id", trace_width'(16'(16'h0105 + i)),
                     trace_width'(rd_data[15:0]));
         idle_cycle(1'b1);
      end
      check_value("empty", trace_width'(1'b1), trace_width'(empty));

      // random traces and pops in a fill phase then a drain phase
      test_name = "concurrent";
      for (i = 0; i < 400; i++) begin
         r    = lcg_next();
         data = lcg_next();
         insn = lcg_next();
         case (r[18:16])
            3'd0, 3'd1, 3'd2: insn[31:16] = 16'h1500;
            3'd3: insn = idle_insn;
            default: insn[31:26] = 6'h27;
         endcase
         pop_req = (i < 200) ? (r[23:20] < 4'd2) : (r[23:20] < 4'd9);
         addr    = r[25] ? 5'd3 : r[30:26];
         freeze  = (r[31:29] == 3'd0);           // about one in eight
         run_cycle(r[24], addr, data, insn, freeze, pop_req);
      end

      // final drain
      test_name = "final_drain";
      drain_all();
      check_value("model queue size", '0, trace_width'(model_q.size()));
      if (uut.u_ringbuffer.rb_assert.fail_count != 0) begin
         $display("a concurrent assertion in the ring buffer failed");
         halt_failed();
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule
